/* design/ciCfg.svh */
`ifndef CI_CFG_SVH
`define CI_CFG_SVH

`default_nettype none

// custom instruction numbers
`define CI_ID_SWAP 8'd1
`define CI_ID_DELAY 8'd6
`define CI_ID_GRAY 8'd9

// reset release after 2**(bits-1) cycles of lock
`define RESET_COUNT_BITS 5

// 100 ns system clock
`define CYCLES_PER_MICROSECOND 10

`default_nettype wire

`endif

/* design/ciPkg.sv */
`default_nettype none

package ciPkg;

  // instruction number as issued by the processor
  typedef logic [7:0] ciId_t;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef struct packed {
    rgb565_t upper;
    rgb565_t lower;
  } pixelPair_t;

  // one operand word, seen as bytes or as two pixels
  typedef union packed {
    logic [3:0][7:0] bytes;
    pixelPair_t pixels;
  } ciWord_t;

endpackage

`default_nettype wire

/* design/resetSequencer.sv */
`timescale 1ns/1ps
`include "ciCfg.svh"
`default_nettype none

module resetSequencer (
  input logic s_systemClock,
  input logic s_pllLocked,
  output logic resetDone,
  output logic unitReset
);

  localparam int unsigned TOP_BIT = `RESET_COUNT_BITS - 1;

  logic [`RESET_COUNT_BITS-1:0] resetCount;

  // saturates once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[TOP_BIT]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign resetDone = resetCount[TOP_BIT];
  assign unitReset = ~resetDone;

  // only a lock loss may take the units back into reset
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    resetDone |=> resetDone)
  else $error("resetDone fell while the PLL stayed locked");

endmodule

`default_nettype wire

/* design/ciDispatch.sv */
`timescale 1ns/1ps
`include "ciCfg.svh"
`default_nettype none

module ciDispatch
  import ciPkg::*;
(
  input logic s_systemClock,
  input logic s_pllLocked,
  input logic resetDone,
  input logic ciStart,
  input ciId_t ciN,
  output logic swapStart,
  output logic grayStart,
  output logic delayStart,
  input logic swapDone,
  input logic grayDone,
  input logic delayDone,
  input ciWord_t swapResult,
  input ciWord_t grayResult,
  input ciWord_t delayResult,
  output logic ciDone,
  output ciWord_t ciResult
);

  logic acceptedStart;
  logic unknownDone;
  logic delayPending;

  // starts during reset are dropped without an answer
  assign acceptedStart = ciStart & resetDone;

  always_comb begin
    swapStart = 1'b0;
    grayStart = 1'b0;
    delayStart = 1'b0;
    unknownDone = 1'b0;
    if (acceptedStart) begin
      case (ciN)
        `CI_ID_SWAP: swapStart = 1'b1;
        `CI_ID_GRAY: grayStart = 1'b1;
        `CI_ID_DELAY: delayStart = 1'b1;
        // no unit behind this number, answer at once with zero
        default: unknownDone = 1'b1;
      endcase
    end
  end

  // units drive zero when idle, so OR merging is safe
  assign ciDone = swapDone | grayDone | delayDone | unknownDone;
  assign ciResult = swapResult | grayResult | delayResult;

  // delay in flight
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      delayPending <= 1'b0;
    end else if (delayStart) begin
      delayPending <= 1'b1;
    end else if (delayDone) begin
      delayPending <= 1'b0;
    end
  end

  // one instruction at a time means one answer at a time
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    $onehot0({swapDone, grayDone, delayDone, unknownDone}))
  else $error("more than one custom instruction done in the same cycle");

  // the processor blocks until the delay unit has answered
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    delayPending |-> !ciStart)
  else $error("new custom instruction started while a delay is outstanding");

endmodule

`default_nettype wire

/* design/byteSwapIse.sv */
`timescale 1ns/1ps
`default_nettype none

module byteSwapIse
  import ciPkg::*;
(
  input logic start,
  input ciWord_t operandA,
  input ciWord_t operandB,
  output logic done,
  output ciWord_t result
);

  logic halfSwap;

  assign halfSwap = operandB.bytes[0][0];

  always_comb begin
    result = '0;
    if (start) begin
      if (halfSwap) begin
        // swap within each 16-bit half
        result.bytes = {operandA.bytes[2], operandA.bytes[3],
                        operandA.bytes[0], operandA.bytes[1]};
      end else begin
        // full endian reversal
        result.bytes = {operandA.bytes[0], operandA.bytes[1],
                        operandA.bytes[2], operandA.bytes[3]};
      end
    end
  end

  assign done = start;

endmodule

`default_nettype wire

/* design/grayscaleIse.sv */
`timescale 1ns/1ps
`default_nettype none

module grayscaleIse
  import ciPkg::*;
(
  input logic start,
  input ciWord_t operandA,
  output logic done,
  output ciWord_t result
);

  rgb565_t pixel;
  logic [15:0] redWide;
  logic [15:0] greenWide;
  logic [15:0] blueWide;
  logic [15:0] luminance;

  // only the lower pixel is converted
  assign pixel = operandA.pixels.lower;

  // widen each channel to 8 bits
  assign redWide = {8'd0, pixel.red, 3'd0};
  assign greenWide = {8'd0, pixel.green, 2'd0};
  assign blueWide = {8'd0, pixel.blue, 3'd0};

  // weights sum to 256, max sum fits in 16 bits
  assign luminance = 16'd54 * redWide + 16'd183 * greenWide + 16'd19 * blueWide;

  always_comb begin
    result = '0;
    if (start) begin
      result.bytes[0] = luminance[15:8];
    end
  end

  assign done = start;

endmodule

`default_nettype wire

/* design/microDelayIse.sv */
`timescale 1ns/1ps
`include "ciCfg.svh"
`default_nettype none

module microDelayIse
  import ciPkg::*;
(
  input logic s_systemClock,
  input logic unitReset,
  input logic start,
  input ciWord_t operandA,
  output logic done,
  output ciWord_t result
);

  // room for a full 32-bit operand times the cycle factor
  localparam int unsigned COUNT_BITS = 40;

  logic busy;
  logic [COUNT_BITS-1:0] remaining;

  // done in cycle N after start, cycle 1 for a zero count
  assign done = busy && (remaining <= COUNT_BITS'(1));

  always_ff @(posedge s_systemClock or posedge unitReset) begin
    if (unitReset) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  // operand is latched here, it is gone after the start cycle
  always_ff @(posedge s_systemClock) begin
    if (start) begin
      remaining <= {8'd0, operandA} * COUNT_BITS'(`CYCLES_PER_MICROSECOND);
    end else if (busy) begin
      remaining <= remaining - COUNT_BITS'(1);
    end
  end

  assign result = '0;

  // every done needs its own start, so never two in a row
  assert property (@(posedge s_systemClock) disable iff (unitReset)
    done |=> !done)
  else $error("delay unit gave done without a new start");

endmodule

`default_nettype wire

/* design/ciSubsystemTop.sv */
`timescale 1ns/1ps
`default_nettype none

module ciSubsystemTop
  import ciPkg::*;
(
  input logic s_systemClock,
  input logic s_pllLocked,
  input logic ciStart,
  input ciId_t ciN,
  input ciWord_t ciDataA,
  input ciWord_t ciDataB,
  output logic ciDone,
  output ciWord_t ciResult,
  output logic resetDone
);

  logic unitReset;
  logic swapStart;
  logic grayStart;
  logic delayStart;
  logic swapDone;
  logic grayDone;
  logic delayDone;
  ciWord_t swapResult;
  ciWord_t grayResult;
  ciWord_t delayResult;

  resetSequencer sequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .resetDone(resetDone),
    .unitReset(unitReset)
  );

  ciDispatch dispatch (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .resetDone(resetDone),
    .ciStart(ciStart),
    .ciN(ciN),
    .swapStart(swapStart),
    .grayStart(grayStart),
    .delayStart(delayStart),
    .swapDone(swapDone),
    .grayDone(grayDone),
    .delayDone(delayDone),
    .swapResult(swapResult),
    .grayResult(grayResult),
    .delayResult(delayResult),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

  byteSwapIse swapUnit (
    .start(swapStart),
    .operandA(ciDataA),
    .operandB(ciDataB),
    .done(swapDone),
    .result(swapResult)
  );

  grayscaleIse grayUnit (
    .start(grayStart),
    .operandA(ciDataA),
    .done(grayDone),
    .result(grayResult)
  );

  // only stateful unit, held in reset until the sequencer releases
  microDelayIse delayUnit (
    .s_systemClock(s_systemClock),
    .unitReset(unitReset),
    .start(delayStart),
    .operandA(ciDataA),
    .done(delayDone),
    .result(delayResult)
  );

endmodule

`default_nettype wire

/* bench/ciSubsystemTb.sv */
`timescale 1ns/1ps
`include "ciCfg.svh"
`default_nettype none

module ciSubsystemTb;

  localparam int DONE_TIMEOUT = 100;
  localparam int RUN_LIMIT_CYCLES = 2000;

  logic s_systemClock;
  logic s_pllLocked;
  logic ciStart;
  logic [7:0] ciN;
  logic [31:0] ciDataA;
  logic [31:0] ciDataB;
  logic ciDone;
  logic [31:0] ciResult;
  logic resetDone;

  int errorCount;
  int checkCount;

  ciSubsystemTop UUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .resetDone(resetDone)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #50 s_systemClock = ~s_systemClock;
  end

  function automatic logic [31:0] reversedBytes(input logic [31:0] word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  function automatic logic [31:0] halfSwappedBytes(input logic [31:0] word);
    return {word[23:16], word[31:24], word[7:0], word[15:8]};
  endfunction

  // widen RGB565 to 8 bits per channel, then weighted sum over 256
  function automatic logic [31:0] expectedGray(input logic [15:0] pixel);
    int red8;
    int green8;
    int blue8;
    red8 = int'(pixel[15:11]) * 8;
    green8 = int'(pixel[10:5]) * 4;
    blue8 = int'(pixel[4:0]) * 8;
    return 32'((54 * red8 + 183 * green8 + 19 * blue8) / 256);
  endfunction

  task automatic checkEqual(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", testName, expected, actual);
      errorCount++;
    end
  endtask

  task automatic reportFailure(input string what);
    $display("Error: %s", what);
    errorCount++;
  endtask

  // latency counts cycles from the start cycle to the done cycle
  task automatic runInstruction(input logic [7:0] id, input logic [31:0] operandA,
                                input logic [31:0] operandB, output int latency,
                                output logic [31:0] answer, output bit timedOut);
    latency = 0;
    timedOut = 1'b0;
    @(posedge s_systemClock);
    #1;
    ciN = id;
    ciDataA = operandA;
    ciDataB = operandB;
    ciStart = 1'b1;
    @(negedge s_systemClock);
    while (!ciDone && !timedOut) begin
      @(posedge s_systemClock);
      #1;
      ciStart = 1'b0;
      // operands are only valid in the start cycle
      ciDataA = $urandom;
      ciDataB = $urandom;
      @(negedge s_systemClock);
      latency++;
      if (latency > DONE_TIMEOUT) begin
        timedOut = 1'b1;
      end
    end
    answer = ciResult;
    @(posedge s_systemClock);
    #1;
    ciStart = 1'b0;
    @(negedge s_systemClock);
    if (ciDone) begin
      reportFailure("done stayed high longer than one cycle");
    end
  endtask

  task automatic resetRelease;
    int edgeCount;
    logic expectHigh;
    @(posedge s_systemClock);
    #1;
    s_pllLocked = 1'b1;
    for (edgeCount = 1; edgeCount <= 20; edgeCount++) begin
      @(posedge s_systemClock);
      #1;
      if (edgeCount == 4) begin
        // must be dropped, the units are still in reset
        ciN = `CI_ID_SWAP;
        ciDataA = $urandom;
        ciDataB = $urandom;
        ciStart = 1'b1;
      end else begin
        ciStart = 1'b0;
      end
      @(negedge s_systemClock);
      expectHigh = (edgeCount >= 16);
      checkEqual("reset release", 32'(expectHigh), 32'(resetDone));
      if (ciDone) begin
        reportFailure("done answered a start issued during reset");
      end
    end
  endtask

  task automatic swapOnce(input string testName, input logic [31:0] operandA,
                          input logic [31:0] operandB);
    int latency;
    logic [31:0] answer;
    bit timedOut;
    logic [31:0] expected;
    expected = operandB[0] ? halfSwappedBytes(operandA) : reversedBytes(operandA);
    runInstruction(`CI_ID_SWAP, operandA, operandB, latency, answer, timedOut);
    if (timedOut) begin
      reportFailure("byte swap never answered");
    end else begin
      checkEqual({testName, " latency"}, 32'd0, 32'(latency));
      checkEqual(testName, expected, answer);
    end
  endtask

  task automatic swapBytes;
    int round;
    logic [31:0] operandB;
    for (round = 0; round < 8; round++) begin
      operandB = $urandom;
      operandB[0] = round[0];
      swapOnce("byte swap", $urandom, operandB);
    end
  endtask

  task automatic convertGray;
    logic [15:0] pixels[$];
    logic [31:0] word;
    int latency;
    logic [31:0] answer;
    bit timedOut;
    int round;
    pixels = '{16'hF800, 16'h07E0, 16'h001F, 16'hFFFF, 16'h0000};
    for (round = 0; round < 6; round++) begin
      pixels.push_back(16'($urandom));
    end
    foreach (pixels[i]) begin
      // upper pixel is random and must not matter
      word = $urandom;
      word[15:0] = pixels[i];
      runInstruction(`CI_ID_GRAY, word, $urandom, latency, answer, timedOut);
      if (timedOut) begin
        reportFailure("grayscale never answered");
      end else begin
        checkEqual("grayscale latency", 32'd0, 32'(latency));
        checkEqual("grayscale", expectedGray(pixels[i]), answer);
      end
    end
  endtask

  task automatic delayMicroseconds;
    logic [31:0] operands[3];
    int expectedCycles;
    int latency;
    logic [31:0] answer;
    bit timedOut;
    operands = '{32'd0, 32'd1, 32'd3};
    foreach (operands[i]) begin
      expectedCycles = int'(operands[i]) * `CYCLES_PER_MICROSECOND;
      if (expectedCycles == 0) begin
        expectedCycles = 1;
      end
      runInstruction(`CI_ID_DELAY, operands[i], $urandom, latency, answer, timedOut);
      if (timedOut) begin
        reportFailure("delay unit never answered");
      end else begin
        checkEqual("delay latency", 32'(expectedCycles), 32'(latency));
        checkEqual("delay result", 32'd0, answer);
      end
    end
  endtask

  task automatic answerUnknown;
    int latency;
    logic [31:0] answer;
    bit timedOut;
    runInstruction(8'd42, $urandom, $urandom, latency, answer, timedOut);
    if (timedOut) begin
      reportFailure("unknown instruction never answered");
    end else begin
      checkEqual("unknown latency", 32'd0, 32'(latency));
      checkEqual("unknown result", 32'd0, answer);
    end
  endtask

  task automatic loseLock;
    int holdCycle;
    @(posedge s_systemClock);
    #1;
    s_pllLocked = 1'b0;
    #1;
    // asynchronous, no clock edge needed
    checkEqual("lock loss", 32'd0, 32'(resetDone));
    for (holdCycle = 0; holdCycle < 5; holdCycle++) begin
      @(negedge s_systemClock);
      checkEqual("lock loss hold", 32'd0, 32'(resetDone));
    end
    resetRelease();
    swapOnce("swap after relock", $urandom, 32'd1);
  endtask

  initial begin
    #(RUN_LIMIT_CYCLES * 100);
    $display("Error: simulation ran past its cycle limit");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    errorCount = 0;
    checkCount = 0;
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = 8'd0;
    ciDataA = 32'd0;
    ciDataB = 32'd0;
    void'($urandom(32'h0076bf12));
    repeat (5) @(posedge s_systemClock);
    if (resetDone !== 1'b0) begin
      reportFailure("resetDone high while the PLL is not locked");
    end
    resetRelease();
    swapBytes();
    convertGray();
    delayMicroseconds();
    answerUnknown();
    loseLock();
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/ciPkg.sv
design/resetSequencer.sv
design/ciDispatch.sv
design/byteSwapIse.sv
design/grayscaleIse.sv
design/microDelayIse.sv
design/ciSubsystemTop.sv
bench/ciSubsystemTb.sv

/* Makefile */
# Verilator simulation of the custom-instruction subsystem

VERILATOR ?= verilator
TOP ?= ciSubsystemTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	rm -f $(LOG)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
